//--- hdl/dataRam.sv
`timescale 1ns/1ps
`default_nettype none

`include "miniAlu_consts.svh"

module dataRam import miniAluPkg::*;
(
   input  wire           Clock,
   input  wire regAddrT  readAddr0,
   input  wire regAddrT  readAddr1,
   output dataT          rdData0,
   output dataT          rdData1,
   input  wire ramWriteT ramWrite
);

   dataT mem [0:`DATA_DEPTH-1];

   // ------------------------------
   // Two read ports, one write port
   // ------------------------------
   // Reads see the old word when an address is written on the same edge
   always_ff @(posedge Clock)
   begin
      if (ramWrite.en)
         mem[ramWrite.addr] <= ramWrite.data;
      rdData0 <= mem[readAddr0];
      rdData1 <= mem[readAddr1];
   end

endmodule

`default_nettype wire

//--- hdl/executeUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "miniAlu_consts.svh"

module executeUnit import miniAluPkg::*;
(
   input  wire        Clock,
   input  wire        arstN,
   input  wire        run,
   input  wire instrT instr,
   input  wire dataT  rdData0,
   input  wire dataT  rdData1,
   output branchT     branch,
   output ramWriteT   ramWrite,
   output logic       ledEn,
   output logic       lcdLoad,
   output logic       lcdIsChar,
   output logic       lcdToggle,
   output dataT       srcData1
);

   localparam instrT nopInstr = '{op: NOP, dest: '0, src1: '0, src0: '0};

   instrT                           exInstr;
   ramWriteT                        lastWrite;
   dataT                            rl;
   dataT                            rh;
   dataT                            srcData0;
   dataT                            immediate;
   logic signed [2*`DATA_WIDTH-1:0] product;
   logic                            smulEn;

   // Forwarding beats RL/RH, which beat the RAM word
   function automatic dataT pickSource(regAddrT addr, dataT ramData, ramWriteT prev,
                                       dataT regL, dataT regH);
      dataT result;
      if (prev.en && (addr == prev.addr))
         result = prev.data;
      else if (addr == `RL_ADDR)
         result = regL;
      else if (addr == `RH_ADDR)
         result = regH;
      else
         result = ramData;
      return result;
   endfunction

   // ------------------------------
   // Fetch/execute register
   // ------------------------------
   always_ff @(posedge Clock or negedge arstN)
   begin
      if (!arstN)
      begin
         exInstr   <= nopInstr;
         lastWrite <= '0;
      end
      else
      begin
         // Idle core executes NOPs
         exInstr   <= run ? instr : nopInstr;
         // Previous write kept for read after write
         lastWrite <= ramWrite;
      end
   end

   // SMUL result halves
   always_ff @(posedge Clock)
   begin
      if (smulEn)
      begin
         rl <= product[`DATA_WIDTH-1:0];
         rh <= product[2*`DATA_WIDTH-1:`DATA_WIDTH];
      end
   end

   // ------------------------------
   // Operand select
   // ------------------------------
   assign srcData0  = pickSource(exInstr.src0, rdData0, lastWrite, rl, rh);
   assign srcData1  = pickSource(exInstr.src1, rdData1, lastWrite, rl, rh);
   assign immediate = dataT'({exInstr.src1, exInstr.src0});
   // Signed 16x16 into 32
   assign product   = srcData1 * srcData0;

   // ------------------------------
   // Opcode decode
   // ------------------------------
   always_comb
   begin
      branch    = '{taken: 1'b0, isCall: 1'b0, isRet: 1'b0, target: exInstr.dest};
      ramWrite  = '{en: 1'b0, addr: exInstr.dest, data: '0};
      ledEn     = 1'b0;
      lcdLoad   = 1'b0;
      lcdIsChar = 1'b0;
      lcdToggle = 1'b0;
      smulEn    = 1'b0;
      case (exInstr.op)
         ADD:
         begin
            ramWrite.en   = 1'b1;
            ramWrite.data = srcData1 + srcData0;
         end
         SUB:
         begin
            ramWrite.en   = 1'b1;
            ramWrite.data = srcData1 - srcData0;
         end
         SHL:
         begin
            ramWrite.en   = 1'b1;
            ramWrite.data = srcData1 << srcData0;
         end
         STO:
         begin
            ramWrite.en   = 1'b1;
            ramWrite.data = immediate;
         end
         // Only RL and RH change
         SMUL:
            smulEn = 1'b1;
         // Signed compare
         BLE:
            branch.taken = (srcData1 <= srcData0);
         JMP:
            branch.taken = 1'b1;
         CALL:
         begin
            branch.taken  = 1'b1;
            branch.isCall = 1'b1;
         end
         RET:
         begin
            branch.taken = 1'b1;
            branch.isRet = 1'b1;
         end
         LED:
            ledEn = 1'b1;
         LCD_CHAR:
         begin
            lcdLoad   = 1'b1;
            lcdIsChar = 1'b1;
         end
         LCD_CMD:
            lcdLoad = 1'b1;
         LCD_ENB:
            lcdToggle = 1'b1;
         // NOP and illegal codes
         default:
         begin
         end
      endcase
   end

endmodule

`default_nettype wire

//--- hdl/instructionPointer.sv
`timescale 1ns/1ps
`default_nettype none

module instructionPointer import miniAluPkg::*;
(
   input  wire         Clock,
   input  wire         arstN,
   input  wire         run,
   input  wire branchT branch,
   output ipT          ip
);

   ipT ipCnt;
   ipT retIp;

   // ------------------------------
   // Next fetch address
   // ------------------------------
   // Taken branch redirects the fetch of this very cycle
   always_comb
   begin
      if (!run)
         ip = '0;
      else if (branch.taken && branch.isRet)
         ip = retIp;
      else if (branch.taken)
         ip = branch.target;
      else
         ip = ipCnt;
   end

   // Sequential counter follows whatever was fetched
   always_ff @(posedge Clock or negedge arstN)
   begin
      if (!arstN)
         ipCnt <= '0;
      else if (!run)
         ipCnt <= '0;
      else
         ipCnt <= ip + 1'b1;
   end

   // Return address
   // During CALL execute the counter already points past the CALL
   always_ff @(posedge Clock or negedge arstN)
   begin
      if (!arstN)
         retIp <= '0;
      else if (run && branch.taken && branch.isCall)
         retIp <= ipCnt;
   end

endmodule

`default_nettype wire

//--- hdl/ioPorts.sv
`timescale 1ns/1ps
`default_nettype none

module ioPorts import miniAluPkg::*;
(
   input  wire       Clock,
   input  wire       arstN,
   input  wire       ledEn,
   input  wire       lcdLoad,
   input  wire       lcdIsChar,
   input  wire       lcdToggle,
   input  wire dataT srcData1,
   output ledT       led,
   output lcdT       lcd
);

   // ------------------------------
   // LED register
   // ------------------------------
   // Low byte of the operand
   always_ff @(posedge Clock or negedge arstN)
   begin
      if (!arstN)
         led <= '0;
      else if (ledEn)
         led <= srcData1[7:0];
   end

   // ------------------------------
   // LCD port
   // ------------------------------
   always_ff @(posedge Clock or negedge arstN)
   begin
      if (!arstN)
         lcd <= '0;
      else
      begin
         // 4-bit bus carries the upper nibble of the low byte
         if (lcdLoad)
         begin
            lcd.rw   <= 1'b0;
            lcd.rs   <= lcdIsChar;
            lcd.data <= srcData1[7:4];
         end
         // Enable strobe flips once per LCD_ENB
         if (lcdToggle)
            lcd.en <= ~lcd.en;
      end
   end

endmodule

`default_nettype wire

//--- hdl/miniAlu.sv
`timescale 1ns/1ps
`default_nettype none

module miniAlu import miniAluPkg::*;
(
   input  wire        Clock,
   input  wire        arstN,
   input  wire wbReqT wbReq,
   output wbRspT      wbRsp,
   output ledT        led,
   output lcdT        lcd
);

   ipT       ip;
   instrT    instr;
   logic     run;
   dataT     rdData0;
   dataT     rdData1;
   branchT   branch;
   ramWriteT ramWrite;
   logic     ledEn;
   logic     lcdLoad;
   logic     lcdIsChar;
   logic     lcdToggle;
   dataT     srcData1;

   // ------------------------------
   // Fetch stage
   // ------------------------------
   programMemory uProgMem (.Clock(Clock), .arstN(arstN), .wbReq(wbReq), .wbRsp(wbRsp),
                           .ip(ip), .instr(instr), .run(run));

   instructionPointer uIp (.Clock(Clock), .arstN(arstN), .run(run), .branch(branch),
                           .ip(ip));

   // Operand reads start from the fetched word
   dataRam uDataRam (.Clock(Clock), .readAddr0(instr.src0), .readAddr1(instr.src1),
                     .rdData0(rdData0), .rdData1(rdData1), .ramWrite(ramWrite));

   // ------------------------------
   // Execute stage and outputs
   // ------------------------------
   executeUnit uExec (.Clock(Clock), .arstN(arstN), .run(run), .instr(instr),
                      .rdData0(rdData0), .rdData1(rdData1), .branch(branch),
                      .ramWrite(ramWrite), .ledEn(ledEn), .lcdLoad(lcdLoad),
                      .lcdIsChar(lcdIsChar), .lcdToggle(lcdToggle), .srcData1(srcData1));

   ioPorts uIo (.Clock(Clock), .arstN(arstN), .ledEn(ledEn), .lcdLoad(lcdLoad),
                .lcdIsChar(lcdIsChar), .lcdToggle(lcdToggle), .srcData1(srcData1),
                .led(led), .lcd(lcd));

endmodule

`default_nettype wire

//--- hdl/miniAluPkg.sv
`default_nettype none

package miniAluPkg;

`include "miniAlu_consts.svh"

   // Basic vectors
   typedef logic [`ADDR_WIDTH-1:0] regAddrT;
   typedef logic signed [`DATA_WIDTH-1:0] dataT;
   typedef logic [`ADDR_WIDTH-1:0] ipT;
   typedef logic [`LED_WIDTH-1:0] ledT;

   // Opcode field, 14 and 15 are illegal
   typedef enum logic [3:0]
   {
      NOP      = 4'd0,
      ADD      = 4'd1,
      SUB      = 4'd2,
      SMUL     = 4'd3,
      STO      = 4'd4,
      BLE      = 4'd5,
      JMP      = 4'd6,
      CALL     = 4'd7,
      RET      = 4'd8,
      LED      = 4'd9,
      LCD_CHAR = 4'd10,
      LCD_CMD  = 4'd11,
      LCD_ENB  = 4'd12,
      SHL      = 4'd13
   } opcodeT;

   // Instruction word, src0 in the low byte
   typedef struct packed
   {
      opcodeT  op;
      regAddrT dest;
      regAddrT src1;
      regAddrT src0;
   } instrT;

   // Execute to IP
   typedef struct packed
   {
      logic taken;
      logic isCall;
      logic isRet;
      ipT   target;
   } branchT;

   // Data memory write port
   typedef struct packed
   {
      logic    en;
      regAddrT addr;
      dataT    data;
   } ramWriteT;

   // LCD pins
   typedef struct packed
   {
      logic       rw;
      logic       rs;
      logic       en;
      logic [3:0] data;
   } lcdT;

   // Wishbone classic, master side
   typedef struct packed
   {
      logic                     cyc;
      logic                     stb;
      logic                     we;
      logic [`WB_ADR_WIDTH-1:0] adr;
      logic [`INSTR_WIDTH-1:0]  dat;
   } wbReqT;

   // Wishbone classic, slave side
   typedef struct packed
   {
      logic                    ack;
      logic [`INSTR_WIDTH-1:0] dat;
   } wbRspT;

endpackage

`default_nettype wire

//--- hdl/miniAlu_consts.svh
`ifndef MINIALU_CONSTS_SVH
`define MINIALU_CONSTS_SVH

// ------------------------------
// Memory sizes
// ------------------------------

// Program words reachable by the IP
`define PROG_DEPTH 256

// Data words addressed by one instruction byte
`define DATA_DEPTH 256

// ------------------------------
// Widths
// ------------------------------

`define INSTR_WIDTH 28
`define DATA_WIDTH 16
// Shared by data addresses and program addresses
`define ADDR_WIDTH 8
`define LED_WIDTH 8
// One extra bit above the program space for the run register
`define WB_ADR_WIDTH 9

// ------------------------------
// Special addresses
// ------------------------------

// SMUL result halves, shadow the top two data words on reads
`define RL_ADDR 8'hFE
`define RH_ADDR 8'hFF

// Run register word address on the bus
`define CTRL_ADR 9'd256

`endif

//--- hdl/programMemory.sv
`timescale 1ns/1ps
`default_nettype none

`include "miniAlu_consts.svh"

module programMemory import miniAluPkg::*;
(
   input  wire        Clock,
   input  wire        arstN,
   input  wire wbReqT wbReq,
   output wbRspT      wbRsp,
   input  wire ipT    ip,
   output instrT      instr,
   output logic       run
);

   instrT                   progMem [0:`PROG_DEPTH-1];
   logic                    ackQ;
   logic                    wbAccess;
   logic                    wbWrite;
   logic                    isCtrl;
   logic                    isProg;
   ipT                      wordAdr;
   logic [`INSTR_WIDTH-1:0] rdDat;

   // ------------------------------
   // Bus decode
   // ------------------------------
   assign wbAccess = wbReq.cyc & wbReq.stb;
   // Write lands on the same edge that raises ack
   assign wbWrite  = wbAccess & wbReq.we & ~ackQ;
   assign isCtrl   = (wbReq.adr == `CTRL_ADR);
   assign isProg   = (wbReq.adr < `PROG_DEPTH);
   assign wordAdr  = wbReq.adr[`ADDR_WIDTH-1:0];

   // One wait state, ack high for a single cycle
   always_ff @(posedge Clock or negedge arstN)
   begin
      if (!arstN)
      begin
         ackQ <= 1'b0;
         run  <= 1'b0;
      end
      else
      begin
         ackQ <= wbAccess & ~ackQ;
         // Run flag in bit 0
         if (wbWrite && isCtrl)
            run <= wbReq.dat[0];
      end
   end

   // Instruction array
   always_ff @(posedge Clock)
   begin
      if (wbWrite && isProg)
         progMem[wordAdr] <= instrT'(wbReq.dat);
   end

   // Readback, held stable by the master until ack
   always_comb
   begin
      rdDat = '0;
      if (isCtrl)
         rdDat[0] = run;
      else if (isProg)
         rdDat = progMem[wordAdr];
   end

   assign wbRsp = '{ack: ackQ, dat: rdDat};

   // Fetch port, no clock
   assign instr = progMem[ip];

endmodule

`default_nettype wire

//--- miniAlu.f
+incdir+hdl
hdl/miniAluPkg.sv
hdl/programMemory.sv
hdl/dataRam.sv
hdl/instructionPointer.sv
hdl/executeUnit.sv
hdl/ioPorts.sv
hdl/miniAlu.sv
verif/miniAluTb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module miniAluTb -f miniAlu.f -o simMiniAlu

out=$(./obj_dir/simMiniAlu)
echo "$out"

if echo "$out" | grep -q "All checks passed"; then
   exit 0
fi
exit 1

//--- verif/miniAluTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "miniAlu_consts.svh"

module miniAluTb import miniAluPkg::*;
();

   localparam int PROG_LEN    = 32;
   localparam int EVENT_COUNT = 12;
   // Two cycles per bus access plus slack
   localparam int BUS_CYCLES  = 3;
   localparam int LOAD_CYCLES = BUS_CYCLES * (2 * `PROG_DEPTH + 2) + 10;
   localparam int CYCLE_LIMIT = LOAD_CYCLES + 40 * EVENT_COUNT;

   // One expected change on led or lcd
   typedef struct packed
   {
      logic isLcd;
      ledT  ledVal;
      lcdT  lcdVal;
   } eventT;

   logic   Clock;
   logic   arstN;
   wbReqT  wbReq;
   wbRspT  wbRsp;
   ledT    led;
   lcdT    lcd;

   instrT  progTable [0:PROG_LEN-1];
   instrT  progImage [0:`PROG_DEPTH-1];
   eventT  eventTable [0:EVENT_COUNT-1];
   integer seed;
   int     errors = 0;
   int     checks = 0;
   int     cycles = 0;
   int     evIdx = 0;
   int     i;
   instrT  rdWord;
   ledT    prevLed;
   lcdT    prevLcd;

   miniAlu uut (.Clock(Clock), .arstN(arstN), .wbReq(wbReq), .wbRsp(wbRsp),
                .led(led), .lcd(lcd));

   // 100 ns clock
   initial
   begin
      Clock = 1'b0;
      forever #50 Clock = ~Clock;
   end

   // Run limit
   always @(posedge Clock)
   begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("Timeout after %0d cycles, only %0d of %0d output events seen",
                  cycles, evIdx, EVENT_COUNT);
         $display("%0d checks, %0d errors", checks, errors);
         $display("Checks failed");
         $finish;
      end
   end

   // ------------------------------
   // Encoding helpers
   // ------------------------------
   function automatic instrT makeInstr(opcodeT op, regAddrT dest, regAddrT src1,
                                       regAddrT src0);
      return '{op: op, dest: dest, src1: src1, src0: src0};
   endfunction

   // Immediate split over src1 and src0
   function automatic instrT storeInstr(regAddrT dest, logic [15:0] imm);
      return makeInstr(STO, dest, imm[15:8], imm[7:0]);
   endfunction

   function automatic eventT ledEvent(ledT value);
      return '{isLcd: 1'b0, ledVal: value, lcdVal: '0};
   endfunction

   // rw always 0
   function automatic eventT lcdEvent(logic rs, logic en, logic [3:0] data);
      return '{isLcd: 1'b1, ledVal: '0, lcdVal: '{rw: 1'b0, rs: rs, en: en, data: data}};
   endfunction

   // ------------------------------
   // Program and expected events
   // ------------------------------
   task automatic buildTables();
      logic [31:0] rnd;
      int          n;
      // Dependent ADD, SUB and SHL back to back
      // 7 + 5 then 5 - 12 then -7 << 7
      progTable[0]  = storeInstr(8'h10, 16'h0007);
      progTable[1]  = storeInstr(8'h11, 16'h0005);
      progTable[2]  = makeInstr(ADD, 8'h12, 8'h10, 8'h11);
      progTable[3]  = makeInstr(SUB, 8'h13, 8'h11, 8'h12);
      progTable[4]  = makeInstr(SHL, 8'h14, 8'h13, 8'h10);
      progTable[5]  = makeInstr(LED, 8'h00, 8'h12, 8'h00);
      progTable[6]  = makeInstr(LED, 8'h00, 8'h13, 8'h00);
      progTable[7]  = makeInstr(LED, 8'h00, 8'h14, 8'h00);
      // -300 * 1000 = 0xFFFB6C20
      progTable[8]  = storeInstr(8'h20, 16'hFED4);
      progTable[9]  = storeInstr(8'h21, 16'h03E8);
      progTable[10] = makeInstr(SMUL, 8'h00, 8'h20, 8'h21);
      progTable[11] = makeInstr(LED, 8'h00, `RL_ADDR, 8'h00);
      progTable[12] = makeInstr(LED, 8'h00, `RH_ADDR, 8'h00);
      // Count up while the count is at most 4
      // Final count 5
      progTable[13] = storeInstr(8'h30, 16'h0000);
      progTable[14] = storeInstr(8'h31, 16'h0001);
      progTable[15] = storeInstr(8'h32, 16'h0004);
      progTable[16] = makeInstr(ADD, 8'h30, 8'h30, 8'h31);
      progTable[17] = makeInstr(BLE, 8'd16, 8'h30, 8'h32);
      progTable[18] = makeInstr(LED, 8'h00, 8'h30, 8'h00);
      // Marker, routine value, LCD command and character
      progTable[19] = storeInstr(8'h33, 16'h00A5);
      progTable[20] = storeInstr(8'h34, 16'h003C);
      progTable[21] = storeInstr(8'h35, 16'h0042);
      progTable[22] = storeInstr(8'h36, 16'h0071);
      progTable[23] = makeInstr(CALL, 8'd30, 8'h00, 8'h00);
      progTable[24] = makeInstr(LED, 8'h00, 8'h33, 8'h00);
      progTable[25] = makeInstr(LCD_CMD, 8'h00, 8'h35, 8'h00);
      progTable[26] = makeInstr(LCD_CHAR, 8'h00, 8'h36, 8'h00);
      progTable[27] = makeInstr(LCD_ENB, 8'h00, 8'h00, 8'h00);
      progTable[28] = makeInstr(LCD_ENB, 8'h00, 8'h00, 8'h00);
      // Park here
      progTable[29] = makeInstr(JMP, 8'd29, 8'h00, 8'h00);
      // Routine
      progTable[30] = makeInstr(LED, 8'h00, 8'h34, 8'h00);
      progTable[31] = makeInstr(RET, 8'h00, 8'h00, 8'h00);

      eventTable[0]  = ledEvent(8'h0C);
      eventTable[1]  = ledEvent(8'hF9);
      eventTable[2]  = ledEvent(8'h80);
      eventTable[3]  = ledEvent(8'h20);
      eventTable[4]  = ledEvent(8'hFB);
      eventTable[5]  = ledEvent(8'h05);
      eventTable[6]  = ledEvent(8'h3C);
      eventTable[7]  = ledEvent(8'hA5);
      eventTable[8]  = lcdEvent(1'b0, 1'b0, 4'h4);
      eventTable[9]  = lcdEvent(1'b1, 1'b0, 4'h7);
      eventTable[10] = lcdEvent(1'b1, 1'b1, 4'h7);
      eventTable[11] = lcdEvent(1'b1, 1'b0, 4'h7);

      // Random filler above the program for readback only
      for (n = 0; n < `PROG_DEPTH; n++)
      begin
         rnd = $random(seed);
         if (n < PROG_LEN)
            progImage[n] = progTable[n];
         else
            progImage[n] = rnd[`INSTR_WIDTH-1:0];
      end
   endtask

   // ------------------------------
   // Wishbone master
   // ------------------------------
   // Entered and left 5 ns after a rising edge
   task automatic wbWrite(input logic [`WB_ADR_WIDTH-1:0] adr,
                          input logic [`INSTR_WIDTH-1:0] dat);
      wbReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
      @(negedge Clock);
      while (!wbRsp.ack)
         @(negedge Clock);
      @(posedge Clock);
      #5;
      wbReq = '0;
   endtask

   task automatic wbRead(input logic [`WB_ADR_WIDTH-1:0] adr,
                         output logic [`INSTR_WIDTH-1:0] dat);
      wbReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0};
      @(negedge Clock);
      while (!wbRsp.ack)
         @(negedge Clock);
      // Data valid with ack
      dat = wbRsp.dat;
      @(posedge Clock);
      #5;
      wbReq = '0;
   endtask

   // ------------------------------
   // Compare tasks
   // ------------------------------
   task automatic checkWord(input instrT got, input instrT exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic checkLed(input ledT got, input ledT exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("mismatch at %0t: %s shows %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic checkLcd(input lcdT got, input lcdT exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("mismatch at %0t: %s rw %b rs %b en %b data %h, expected %b %b %b %h",
                  $time, what, got.rw, got.rs, got.en, got.data,
                  exp.rw, exp.rs, exp.en, exp.data);
      end
   endtask

   // Next table entry against the output that just changed
   task automatic takeEvent(input logic isLcd);
      if (evIdx >= EVENT_COUNT)
      begin
         errors++;
         $display("Unexpected %s change at %0t after the last expected event",
                  isLcd ? "LCD" : "LED", $time);
      end
      else
      begin
         if (eventTable[evIdx].isLcd != isLcd)
         begin
            errors++;
            $display("Wrong output changed at %0t, event %0d is a change on %s",
                     $time, evIdx, eventTable[evIdx].isLcd ? "LCD" : "LED");
         end
         else if (isLcd)
            checkLcd(lcd, eventTable[evIdx].lcdVal, $sformatf("LCD event %0d", evIdx));
         else
            checkLed(led, eventTable[evIdx].ledVal, $sformatf("LED event %0d", evIdx));
         evIdx++;
      end
   endtask

   // ------------------------------
   // Main sequence
   // ------------------------------
   initial
   begin
      seed  = 15072;
      arstN = 1'b0;
      wbReq = '0;
      buildTables();
      repeat (2) @(posedge Clock);
      #5;
      arstN = 1'b1;

      // Outputs idle after reset
      @(negedge Clock);
      checkLed(led, '0, "LED after reset");
      checkLcd(lcd, '0, "LCD after reset");
      checks++;
      if (wbRsp.ack !== 1'b0)
      begin
         errors++;
         $display("mismatch at %0t: ack high after reset", $time);
      end
      @(posedge Clock);
      #5;
      wbRead(`CTRL_ADR, rdWord);
      checkWord(rdWord, '0, "run register after reset");

      // Load then read every word back
      for (i = 0; i < `PROG_DEPTH; i++)
         wbWrite(i[`WB_ADR_WIDTH-1:0], progImage[i]);
      for (i = 0; i < `PROG_DEPTH; i++)
      begin
         wbRead(i[`WB_ADR_WIDTH-1:0], rdWord);
         checkWord(rdWord, progImage[i], $sformatf("program word %0d", i));
      end

      // Start the core
      wbWrite(`CTRL_ADR, 28'd1);
      prevLed = led;
      prevLcd = lcd;
      while (evIdx < EVENT_COUNT)
      begin
         @(negedge Clock);
         if (led !== prevLed)
            takeEvent(1'b0);
         if (lcd !== prevLcd)
            takeEvent(1'b1);
         prevLed = led;
         prevLcd = lcd;
      end

      // Outputs stay put while the core spins on its JMP
      repeat (16)
      begin
         @(negedge Clock);
         if (led !== prevLed)
            takeEvent(1'b0);
         if (lcd !== prevLcd)
            takeEvent(1'b1);
         prevLed = led;
         prevLcd = lcd;
      end

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire
